// File: logic/rob_params.svh
// Width and depth macros for the out-of-order back end.
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~
`define DATA_W 32                                   // Operand and result width.
`define REG_W 5                                     // Destination register index.

// ~~~~~~~~~~~~~~~~~~~~
// Reorder buffer size
// ~~~~~~~~~~~~~~~~~~~~
// Depth must be a power of two; TAG_W changes with it.
`define ROB_DEPTH 8
`define TAG_W 3                                     // Log2 of ROB_DEPTH.

`endif

// File: logic/rob_pkg.sv
// Opcode enum and tag, register-index and data types.
`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Opcodes
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_XOR   = 3'd2,
        OP_MUL   = 3'd3,                            // Goes to the multiplier.
        OP_STORE = 3'd4                             // Passes operand a, no dest write.
    } op_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Common types
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [`TAG_W-1:0]  rob_tag_t;          // Reorder buffer entry index.
    typedef logic [`REG_W-1:0]  reg_idx_t;
    typedef logic [`DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// File: logic/rob_ifs.sv
// Interfaces alloc_if, issue_if and complete_if.
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

// Entry allocation, decode to reorder buffer.
interface alloc_if import rob_pkg::*; ();
    logic     alloc;
    rob_tag_t tag;                                  // Current tail.
    reg_idx_t dst;
    logic     dst_valid;
    logic     is_store;
    logic     full;

    modport decode (
        output alloc, dst, dst_valid, is_store,
        input  tag, full
    );

    modport buffer (
        input  alloc, dst, dst_valid, is_store,
        output tag, full
    );
endinterface

// Instruction issue, decode to one execution unit.
interface issue_if import rob_pkg::*; ();
    logic     valid;                                // One-cycle strobe.
    rob_tag_t tag;
    op_e      op;
    data_t    a;
    data_t    b;

    modport source (output valid, tag, op, a, b);
    modport sink   (input  valid, tag, op, a, b);
endinterface

// Completion, execution unit to reorder buffer.
interface complete_if import rob_pkg::*; ();
    logic     valid;
    rob_tag_t tag;
    data_t    value;

    modport source (output valid, tag, value);
    modport sink   (input  valid, tag, value);
endinterface

`default_nettype wire

// File: logic/insn_decode.sv
// Decode stage: instruction accept, entry allocation and unit routing.
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module insn_decode import rob_pkg::*; (
    input  wire      clk,
    input  wire      reset,

    input  wire      insn_valid_i,
    input  op_e      insn_op_i,
    input  reg_idx_t insn_dst_i,
    input  data_t    insn_a_i,
    input  data_t    insn_b_i,
    output logic     insn_ready_o,

    alloc_if.decode  alloc,
    issue_if.source  alu_issue,
    issue_if.source  mul_issue
);

    logic accept;
    logic is_mul;
    logic is_store;

    // ~~~~~~~~~~~~~~~~~~~~
    // Accept and allocate
    // ~~~~~~~~~~~~~~~~~~~~
    assign insn_ready_o = ~alloc.full;
    assign accept       = insn_valid_i & insn_ready_o;

    assign is_mul   = (insn_op_i == OP_MUL);
    assign is_store = (insn_op_i == OP_STORE);

    assign alloc.alloc     = accept;
    assign alloc.dst       = insn_dst_i;
    assign alloc.dst_valid = ~is_store;             // Stores have no dest.
    assign alloc.is_store  = is_store;

    // ~~~~~~~~~~~~~~~~~~~~
    // Issue registers
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            alu_issue.valid <= 1'b0;
            mul_issue.valid <= 1'b0;
        end else begin
            alu_issue.valid <= accept & ~is_mul;
            mul_issue.valid <= accept & is_mul;
        end
    end

    // Payload only loads for the unit that gets the instruction.
    always_ff @(posedge clk) begin
        if (accept && !is_mul) begin
            alu_issue.tag <= alloc.tag;
            alu_issue.op  <= insn_op_i;
            alu_issue.a   <= insn_a_i;
            alu_issue.b   <= insn_b_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_mul) begin
            mul_issue.tag <= alloc.tag;
            mul_issue.op  <= insn_op_i;
            mul_issue.a   <= insn_a_i;
            mul_issue.b   <= insn_b_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_units.sv
// Execution units: single-cycle ALU and three-stage multiplier.
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module exec_units import rob_pkg::*; (
    input  wire        clk,
    input  wire        reset,

    issue_if.sink      alu_issue,
    issue_if.sink      mul_issue,

    complete_if.source alu_done,
    complete_if.source mul_done
);

    data_t    alu_result;

    logic     s1_valid;
    rob_tag_t s1_tag;
    data_t    s1_a;
    data_t    s1_b;

    logic     s2_valid;
    rob_tag_t s2_tag;
    data_t    s2_prod;

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (alu_issue.op)
            OP_ADD:   alu_result = alu_issue.a + alu_issue.b;
            OP_SUB:   alu_result = alu_issue.a - alu_issue.b;
            OP_XOR:   alu_result = alu_issue.a ^ alu_issue.b;
            OP_STORE: alu_result = alu_issue.a;     // Store data.
            default:  alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_done.valid <= 1'b0;
        end else begin
            alu_done.valid <= alu_issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        alu_done.tag   <= alu_issue.tag;
        alu_done.value <= alu_result;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Multiplier pipeline
    // ~~~~~~~~~~~~~~~~~~~~
    // Operand, product and output registers; one multiply per stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid       <= 1'b0;
            s2_valid       <= 1'b0;
            mul_done.valid <= 1'b0;
        end else begin
            s1_valid       <= mul_issue.valid;
            s2_valid       <= s1_valid;
            mul_done.valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag <= mul_issue.tag;
        s1_a   <= mul_issue.a;
        s1_b   <= mul_issue.b;

        s2_tag  <= s1_tag;
        s2_prod <= s1_a * s1_b;                     // Low half of product.

        mul_done.tag   <= s2_tag;
        mul_done.value <= s2_prod;
    end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
// Reorder buffer: entry storage, completion marking and two-wide commit.
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module reorder_buffer import rob_pkg::*; (
    input  wire      clk,
    input  wire      reset,

    alloc_if.buffer  alloc,
    complete_if.sink alu_done,
    complete_if.sink mul_done,

    output logic     commit_valid_1_o,
    output logic     commit_we_1_o,
    output reg_idx_t commit_dst_1_o,
    output data_t    commit_data_1_o,
    output logic     commit_store_1_o,

    output logic     commit_valid_2_o,
    output logic     commit_we_2_o,
    output reg_idx_t commit_dst_2_o,
    output data_t    commit_data_2_o,
    output logic     commit_store_2_o
);

    localparam int CNT_W = `TAG_W + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Entry state
    // ~~~~~~~~~~~~~~~~~~~~
    logic [`ROB_DEPTH-1:0] finish;
    reg_idx_t              dst_q       [`ROB_DEPTH];
    logic                  dst_valid_q [`ROB_DEPTH];
    logic                  store_q     [`ROB_DEPTH];
    data_t                 value_q     [`ROB_DEPTH];

    rob_tag_t              head;
    rob_tag_t              head_2;
    rob_tag_t              tail;
    logic [CNT_W-1:0]      count;

    logic                  commit_1;
    logic                  commit_2;
    logic [1:0]            commit_cnt;

    assign alloc.tag  = tail;
    assign alloc.full = (count == CNT_W'(`ROB_DEPTH));

    // ~~~~~~~~~~~~~~~~~~~~
    // Commit selection
    // ~~~~~~~~~~~~~~~~~~~~
    assign head_2 = head + 1'b1;                    // Wraps with the tag width.

    assign commit_1   = (count != '0) & finish[head];
    assign commit_2   = commit_1 & (count > CNT_W'(1)) & finish[head_2];
    assign commit_cnt = {1'b0, commit_1} + {1'b0, commit_2};

    assign commit_valid_1_o = commit_1;
    assign commit_we_1_o    = commit_1 & dst_valid_q[head];
    assign commit_dst_1_o   = dst_q[head];
    assign commit_data_1_o  = value_q[head];
    assign commit_store_1_o = commit_1 & store_q[head];

    assign commit_valid_2_o = commit_2;
    assign commit_we_2_o    = commit_2 & dst_valid_q[head_2];
    assign commit_dst_2_o   = dst_q[head_2];
    assign commit_data_2_o  = value_q[head_2];
    assign commit_store_2_o = commit_2 & store_q[head_2];

    // ~~~~~~~~~~~~~~~~~~~~
    // Pointers and finish bits
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            finish <= '0;
        end else begin
            head  <= head + rob_tag_t'(commit_cnt);
            count <= count + CNT_W'(alloc.alloc) - CNT_W'(commit_cnt);

            if (alloc.alloc) begin
                tail         <= tail + 1'b1;
                finish[tail] <= 1'b0;               // New entry not done.
            end
            if (alu_done.valid) begin
                finish[alu_done.tag] <= 1'b1;
            end
            if (mul_done.valid) begin
                finish[mul_done.tag] <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Entry payload
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (alloc.alloc) begin
            dst_q[tail]       <= alloc.dst;
            dst_valid_q[tail] <= alloc.dst_valid;
            store_q[tail]     <= alloc.is_store;
        end
    end

    // Both units can write here in one cycle, always to different tags.
    always_ff @(posedge clk) begin
        if (alu_done.valid) begin
            value_q[alu_done.tag] <= alu_done.value;
        end
        if (mul_done.valid) begin
            value_q[mul_done.tag] <= mul_done.value;
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_core_top.sv
// Back-end top level: decode, execution units and reorder buffer.
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_core_top import rob_pkg::*; (
    input  wire      clk,
    input  wire      reset,

    input  wire      insn_valid_i,
    input  op_e      insn_op_i,
    input  reg_idx_t insn_dst_i,
    input  data_t    insn_a_i,
    input  data_t    insn_b_i,
    output logic     insn_ready_o,

    output logic     commit_valid_1_o,
    output logic     commit_we_1_o,
    output reg_idx_t commit_dst_1_o,
    output data_t    commit_data_1_o,
    output logic     commit_store_1_o,

    output logic     commit_valid_2_o,
    output logic     commit_we_2_o,
    output reg_idx_t commit_dst_2_o,
    output data_t    commit_data_2_o,
    output logic     commit_store_2_o
);

    alloc_if    alloc ();
    issue_if    alu_issue ();
    issue_if    mul_issue ();
    complete_if alu_done ();
    complete_if mul_done ();

    insn_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .insn_valid_i (insn_valid_i),
        .insn_op_i    (insn_op_i),
        .insn_dst_i   (insn_dst_i),
        .insn_a_i     (insn_a_i),
        .insn_b_i     (insn_b_i),
        .insn_ready_o (insn_ready_o),
        .alloc        (alloc.decode),
        .alu_issue    (alu_issue.source),
        .mul_issue    (mul_issue.source)
    );

    exec_units u_exec (
        .clk       (clk),
        .reset     (reset),
        .alu_issue (alu_issue.sink),
        .mul_issue (mul_issue.sink),
        .alu_done  (alu_done.source),
        .mul_done  (mul_done.source)
    );

    reorder_buffer u_rob (
        .clk              (clk),
        .reset            (reset),
        .alloc            (alloc.buffer),
        .alu_done         (alu_done.sink),
        .mul_done         (mul_done.sink),
        .commit_valid_1_o (commit_valid_1_o),
        .commit_we_1_o    (commit_we_1_o),
        .commit_dst_1_o   (commit_dst_1_o),
        .commit_data_1_o  (commit_data_1_o),
        .commit_store_1_o (commit_store_1_o),
        .commit_valid_2_o (commit_valid_2_o),
        .commit_we_2_o    (commit_we_2_o),
        .commit_dst_2_o   (commit_dst_2_o),
        .commit_data_2_o  (commit_data_2_o),
        .commit_store_2_o (commit_store_2_o)
    );

endmodule

`default_nettype wire

// File: verification/rob_core_tb.sv
// Directed testbench for rob_core_top with reference model, compare tasks and six tests.
`timescale 1ns/1ps
`default_nettype none

module rob_core_tb import rob_pkg::*; ();

    typedef struct packed {
        op_e      op;
        reg_idx_t dst;
        data_t    value;
        logic     store;
    } exp_t;

    typedef struct packed {
        logic        we;
        reg_idx_t    dst;
        data_t       data;
        logic        store;
        logic [1:0]  slot;
        logic [31:0] cyc;
    } obs_t;

    logic     clk;
    logic     reset;
    logic     insn_valid_i;
    op_e      insn_op_i;
    reg_idx_t insn_dst_i;
    data_t    insn_a_i;
    data_t    insn_b_i;
    logic     insn_ready_o;
    logic     commit_valid_1_o;
    logic     commit_we_1_o;
    reg_idx_t commit_dst_1_o;
    data_t    commit_data_1_o;
    logic     commit_store_1_o;
    logic     commit_valid_2_o;
    logic     commit_we_2_o;
    reg_idx_t commit_dst_2_o;
    data_t    commit_data_2_o;
    logic     commit_store_2_o;

    exp_t   exp_q [$];
    obs_t   obs_q [$];
    string  cur_test;
    int     errors;
    int     checks;
    int     tests_run;
    int     test_errors;
    int     cycle_cnt;
    integer seed;

    rob_core_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #1_000_000;
        abort_run("Simulation watchdog expired before the tests finished");
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Commit monitor
    // ~~~~~~~~~~~~~~~~~~~~
    // Outputs are settled at the falling edge; slot 1 is logged first.
    always @(negedge clk) begin
        if (!reset && commit_valid_1_o) begin
            record_commit(commit_we_1_o, commit_dst_1_o, commit_data_1_o, commit_store_1_o, 1);
        end
        if (!reset && commit_valid_2_o) begin
            record_commit(commit_we_2_o, commit_dst_2_o, commit_data_2_o, commit_store_2_o, 2);
        end
    end

    task automatic record_commit(logic we, reg_idx_t dst, data_t data, logic st, int slot);
        obs_t o;
        o.we    = we;
        o.dst   = dst;
        o.data  = data;
        o.store = st;
        o.slot  = slot[1:0];
        o.cyc   = cycle_cnt;
        obs_q.push_back(o);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model and compares
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic data_t model_value(op_e op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;                   // Low 32 bits kept.
            default: return a;                       // Store data is operand a.
        endcase
    endfunction

    task automatic check_data(string what, data_t exp, data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_reg(string what, reg_idx_t exp, reg_idx_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch in %s (%s): expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch in %s (%s): expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Drive and drain helpers
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_insn(op_e op, reg_idx_t dst, data_t a, data_t b);
        exp_t e;
        int   waited;
        insn_valid_i = 1'b1;
        insn_op_i    = op;
        insn_dst_i   = dst;
        insn_a_i     = a;
        insn_b_i     = b;
        waited       = 0;
        while (!insn_ready_o) begin                  // Hold until the buffer has room.
            if (waited >= 100) abort_run("insn_ready_o stayed low for 100 cycles");
            idle(1);
            waited++;
        end
        e.op    = op;
        e.dst   = dst;
        e.value = model_value(op, a, b);
        e.store = (op == OP_STORE);
        exp_q.push_back(e);
        idle(1);
        insn_valid_i = 1'b0;
    endtask

    task automatic drain_and_compare();
        int    waited;
        string tag;
        waited = 0;
        while (obs_q.size() < exp_q.size()) begin
            if (waited >= 300) begin
                abort_run($sformatf("Timeout in %s: %0d of %0d retirements arrived",
                                    cur_test, obs_q.size(), exp_q.size()));
            end
            idle(1);
            waited++;
        end
        idle(5);                                     // Window for stray commits.
        if (obs_q.size() != exp_q.size()) begin
            errors++;
            $display("%s saw %0d commits where %0d were expected",
                     cur_test, obs_q.size(), exp_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < obs_q.size(); i++) begin
            tag = $sformatf("retire %0d %s", i, exp_q[i].op.name());
            check_flag({tag, " write"}, !exp_q[i].store, obs_q[i].we);
            check_flag({tag, " store"}, exp_q[i].store, obs_q[i].store);
            if (!exp_q[i].store) begin
                check_reg({tag, " dst"}, exp_q[i].dst, obs_q[i].dst);
            end
            check_data({tag, " data"}, exp_q[i].value, obs_q[i].data);
        end
    endtask

    task automatic start_test(string name);
        cur_test    = name;
        test_errors = errors;
        exp_q.delete();
        obs_q.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) $display("%s: ok", cur_test);
        else $display("%s: %0d errors", cur_test, errors - test_errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_state();
        start_test("reset_state");
        check_flag("ready after reset", 1'b1, insn_ready_o);
        repeat (10) begin
            idle(1);
            check_flag("commit strobe while idle", 1'b0,
                       |{commit_valid_1_o, commit_we_1_o, commit_store_1_o,
                         commit_valid_2_o, commit_we_2_o, commit_store_2_o});
        end
        end_test();
    endtask

    task automatic test_alu_ops();
        start_test("alu_ops");
        send_insn(OP_ADD, 5'd1, 32'h1234_5678, 32'h0fed_cba9);
        send_insn(OP_SUB, 5'd2, 32'd5, 32'd7);
        send_insn(OP_XOR, 5'd3, 32'hdead_beef, 32'hffff_0000);
        drain_and_compare();
        end_test();
    endtask

    task automatic test_unit_order();
        start_test("unit_order");
        send_insn(OP_MUL, 5'd4, 32'h0001_0003, 32'h0000_0105);
        send_insn(OP_ADD, 5'd5, 32'd100, 32'd23);
        drain_and_compare();
        end_test();
    endtask

    task automatic test_dual_commit();
        start_test("dual_commit");
        send_insn(OP_MUL, 5'd6, 32'd12345, 32'd6789);
        send_insn(OP_ADD, 5'd7, 32'd1, 32'd2);
        send_insn(OP_ADD, 5'd8, 32'd3, 32'd4);
        drain_and_compare();
        if (obs_q.size() >= 2) begin
            check_flag("first ADD on slot 2", 1'b1, obs_q[1].slot == 2'd2);
            check_flag("MUL and ADD same cycle", 1'b1, obs_q[0].cyc == obs_q[1].cyc);
        end
        end_test();
    endtask

    task automatic test_store();
        start_test("store");
        send_insn(OP_ADD, 5'd9, 32'd10, 32'd20);
        send_insn(OP_STORE, 5'd10, 32'hcafe_f00d, 32'h1111_2222);
        send_insn(OP_ADD, 5'd11, 32'd30, 32'd40);
        drain_and_compare();
        end_test();
    endtask

    task automatic test_random_stream();
        op_e op;
        start_test("random_stream");
        for (int i = 0; i < 60; i++) begin
            op = op_e'($unsigned($random(seed)) % 5);
            send_insn(op, reg_idx_t'($random(seed)),
                      data_t'($random(seed)), data_t'($random(seed)));
            idle($unsigned($random(seed)) % 4);      // Idle gap of 0 to 3 cycles.
        end
        drain_and_compare();
        end_test();
    endtask

    initial begin
        seed         = 32'h3155_80c0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        cycle_cnt    = 0;
        reset        = 1'b1;
        insn_valid_i = 1'b0;
        insn_op_i    = OP_ADD;
        insn_dst_i   = '0;
        insn_a_i     = '0;
        insn_b_i     = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_alu_ops();
        test_unit_order();
        test_dual_commit();
        test_store();
        test_random_stream();

        $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_ifs.sv
logic/insn_decode.sv
logic/exec_units.sv
logic/reorder_buffer.sv
logic/rob_core_top.sv
verification/rob_core_tb.sv
